// File: src/icache_pkg.sv
// ----------------------------------------------------------------------
// instruction cache shared types
// ----------------------------------------------------------------------
`default_nettype none

package icache_pkg;

	// word addressed, 32 bit instructions
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;

	localparam int LINE_WORDS = 8;
	localparam int OFFSET_BITS = 3;

	// one full line as returned by memory
	typedef logic [LINE_WORDS*32-1:0] line_t;

	typedef logic [31:0] cnt_t;

	// held by the cpu until resp is seen
	typedef struct packed {
		logic read;
		addr_t addr;
	} cpu_req_t;

	typedef struct packed {
		logic resp;
		word_t rdata;
	} cpu_rsp_t;

	// addr is the line base, offset bits zero
	typedef struct packed {
		logic valid;
		addr_t addr;
	} mem_req_t;

	typedef struct packed {
		logic valid;
		line_t line;
	} mem_rsp_t;

	typedef struct packed {
		cnt_t hits;
		cnt_t pf_hits;
		cnt_t misses;
		cnt_t miss_cycles;
	} perf_counts_t;

	typedef enum logic [1:0] {
		s_idle,
		s_load_instr,
		s_load_prefetch
	} ctrl_state_e;

endpackage : icache_pkg

`default_nettype wire

// File: src/i_cache_datapath.sv
// ----------------------------------------------------------------------
// instruction cache arrays and tag compare
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module i_cache_datapath #(
	parameter int SET_BITS = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  icache_pkg::addr_t  cpu_addr_i,
	input  logic               way_sel_i,
	input  logic               load_line_i,
	input  logic               load_lru_i,
	input  logic               prefetch_sel_i,
	input  logic               set_busy_i,
	input  logic               clr_busy_i,
	input  logic               set_prefetched_i,
	input  logic               clr_prefetched_i,
	input  icache_pkg::line_t  fill_line_i,
	output logic               hit_o,
	output logic               hit_way_o,
	output logic               obl_hit_o,
	output logic               obl_busy_o,
	output logic               lru_o,
	output logic               obl_lru_o,
	output logic               hit_prefetched_o,
	output icache_pkg::word_t  rdata_o,
	output icache_pkg::addr_t  fill_addr_o
);
	import icache_pkg::*;

	localparam int SETS = 1 << SET_BITS;
	localparam int ADDR_BITS = $bits(addr_t);
	localparam int WORD_BITS = $bits(word_t);
	localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS - SET_BITS;

	typedef logic [SET_BITS-1:0] idx_t;
	typedef logic [TAG_BITS-1:0] tag_t;

	// storage, indexed [way][set]
	tag_t tag_q [2][SETS];
	line_t data_q [2][SETS];
	logic [SETS-1:0] valid_q [2];
	logic [SETS-1:0] busy_q [2];
	logic [SETS-1:0] pf_q [2];
	// lru_q holds the way to evict next
	logic [SETS-1:0] lru_q;
	// lookahead line captured when the prefetch starts
	addr_t pf_addr_q;

	addr_t dem_line;
	addr_t obl_line;
	idx_t dem_idx;
	idx_t obl_idx;
	idx_t fill_idx;
	tag_t dem_tag;
	tag_t obl_tag;
	tag_t fill_tag;
	logic [1:0] dem_match;
	logic [1:0] obl_match;
	logic dem_set_busy;
	logic [OFFSET_BITS-1:0] offset;

	// demand line and next sequential line
	assign dem_line = {cpu_addr_i[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	assign obl_line = dem_line + addr_t'(LINE_WORDS);
	assign offset = cpu_addr_i[OFFSET_BITS-1:0];

	assign dem_idx = dem_line[OFFSET_BITS +: SET_BITS];
	assign dem_tag = dem_line[ADDR_BITS-1 -: TAG_BITS];
	assign obl_idx = obl_line[OFFSET_BITS +: SET_BITS];
	assign obl_tag = obl_line[ADDR_BITS-1 -: TAG_BITS];

	// fill target, either the held demand line or the latched lookahead
	assign fill_addr_o = prefetch_sel_i ? pf_addr_q : dem_line;
	assign fill_idx = fill_addr_o[OFFSET_BITS +: SET_BITS];
	assign fill_tag = fill_addr_o[ADDR_BITS-1 -: TAG_BITS];

	// both lookups side by side
	always_comb begin
		for (int w = 0; w < 2; w++) begin
			dem_match[w] = valid_q[w][dem_idx] && (tag_q[w][dem_idx] == dem_tag);
			obl_match[w] = valid_q[w][obl_idx] && (tag_q[w][obl_idx] == obl_tag);
		end
	end

	// a set with a line in flight answers no demand reads
	assign dem_set_busy = busy_q[0][dem_idx] | busy_q[1][dem_idx];

	assign hit_o = (|dem_match) & ~dem_set_busy;
	assign hit_way_o = dem_match[1];
	assign hit_prefetched_o = pf_q[hit_way_o][dem_idx];
	assign lru_o = lru_q[dem_idx];

	assign obl_hit_o = |obl_match;
	assign obl_busy_o = busy_q[0][obl_idx] | busy_q[1][obl_idx];
	assign obl_lru_o = lru_q[obl_idx];

	// word select from the hit way
	assign rdata_o = data_q[hit_way_o][dem_idx][offset * WORD_BITS +: WORD_BITS];

	// tag and line storage
	always_ff @(posedge clk) begin
		if (load_line_i) begin
			tag_q[way_sel_i][fill_idx] <= fill_tag;
			data_q[way_sel_i][fill_idx] <= fill_line_i;
		end
	end

	always_ff @(posedge clk) begin
		if (set_busy_i) begin
			pf_addr_q <= obl_line;
		end
	end

	// per line status and per set lru
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '{default: '0};
			busy_q <= '{default: '0};
			pf_q <= '{default: '0};
			lru_q <= '0;
		end else begin
			if (load_line_i) begin
				valid_q[way_sel_i][fill_idx] <= 1'b1;
			end
			// the way just used becomes most recent
			if (load_lru_i) begin
				lru_q[dem_idx] <= ~way_sel_i;
			end
			// lookahead victim is reserved in the hit cycle
			if (set_busy_i) begin
				busy_q[obl_lru_o][obl_idx] <= 1'b1;
			end
			if (clr_busy_i) begin
				busy_q[way_sel_i][fill_idx] <= 1'b0;
			end
			if (set_prefetched_i) begin
				pf_q[way_sel_i][fill_idx] <= 1'b1;
			end
			// first demand hit or a demand fill drops the mark
			if (clr_prefetched_i) begin
				pf_q[way_sel_i][dem_idx] <= 1'b0;
			end
		end
	end

endmodule : i_cache_datapath

`default_nettype wire

// File: src/i_cache_control.sv
// ----------------------------------------------------------------------
// instruction cache control FSM
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module i_cache_control #(
	parameter int MEM_CREDITS = 2
) (
	input  logic                  clk,
	input  logic                  rst,
	input  icache_pkg::cpu_req_t  cpu_req_i,
	output logic                  resp_o,
	input  logic                  hit_i,
	input  logic                  hit_way_i,
	input  logic                  obl_hit_i,
	input  logic                  obl_busy_i,
	input  logic                  lru_i,
	input  logic                  obl_lru_i,
	input  logic                  hit_prefetched_i,
	output logic                  way_sel_o,
	output logic                  load_line_o,
	output logic                  load_lru_o,
	output logic                  prefetch_sel_o,
	output logic                  set_busy_o,
	output logic                  clr_busy_o,
	output logic                  set_prefetched_o,
	output logic                  clr_prefetched_o,
	input  logic                  mem_credit_i,
	output logic                  mem_req_valid_o,
	input  logic                  mem_rsp_valid_i,
	output logic                  ev_hit_o,
	output logic                  ev_pf_hit_o,
	output logic                  ev_miss_o,
	output logic                  ev_miss_cycle_o
);
	import icache_pkg::*;

	localparam int CREDIT_BITS = $clog2(MEM_CREDITS + 1);

	typedef logic [CREDIT_BITS-1:0] credit_t;

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	credit_t credits_q;
	credit_t credits_d;
	// one request out, waiting for its line
	logic req_sent_q;
	// way reserved for the prefetch fill
	logic pf_way_q;
	logic demand_hit;

	assign demand_hit = cpu_req_i.read & hit_i;

	// one request per load state, only with a credit in hand
	assign mem_req_valid_o = (state_q != s_idle) & ~req_sent_q & (credits_q != '0);

	always_comb begin
		state_d = state_q;
		resp_o = 1'b0;
		way_sel_o = hit_way_i;
		load_line_o = 1'b0;
		load_lru_o = 1'b0;
		prefetch_sel_o = 1'b0;
		set_busy_o = 1'b0;
		clr_busy_o = 1'b0;
		set_prefetched_o = 1'b0;
		clr_prefetched_o = 1'b0;
		ev_hit_o = 1'b0;
		ev_pf_hit_o = 1'b0;
		ev_miss_o = 1'b0;
		ev_miss_cycle_o = 1'b0;

		case (state_q)
			s_idle: begin
				if (demand_hit) begin
					resp_o = 1'b1;
					load_lru_o = 1'b1;
					ev_hit_o = 1'b1;
					if (hit_prefetched_i) begin
						ev_pf_hit_o = 1'b1;
						clr_prefetched_o = 1'b1;
					end
					// next line absent, start fetching it
					if (~obl_hit_i & ~obl_busy_i) begin
						set_busy_o = 1'b1;
						state_d = s_load_prefetch;
					end
				end else if (cpu_req_i.read) begin
					ev_miss_o = 1'b1;
					state_d = s_load_instr;
				end
			end

			s_load_instr: begin
				// demand fill goes to the lru way
				way_sel_o = lru_i;
				ev_miss_cycle_o = 1'b1;
				if (mem_rsp_valid_i) begin
					load_line_o = 1'b1;
					clr_prefetched_o = 1'b1;
					state_d = s_idle;
				end
			end

			s_load_prefetch: begin
				prefetch_sel_o = 1'b1;
				if (mem_rsp_valid_i) begin
					way_sel_o = pf_way_q;
					load_line_o = 1'b1;
					clr_busy_o = 1'b1;
					set_prefetched_o = 1'b1;
					state_d = s_idle;
				end else if (demand_hit) begin
					// hits outside the busy set still served
					resp_o = 1'b1;
					load_lru_o = 1'b1;
					ev_hit_o = 1'b1;
					if (hit_prefetched_i) begin
						ev_pf_hit_o = 1'b1;
						clr_prefetched_o = 1'b1;
					end
				end
			end

			default: state_d = s_idle;
		endcase
	end

	// credit count, consumed by each request
	always_comb begin
		credits_d = credits_q;
		if (mem_req_valid_o) begin
			credits_d = credits_d - credit_t'(1);
		end
		if (mem_credit_i && (credits_d != credit_t'(MEM_CREDITS))) begin
			credits_d = credits_d + credit_t'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= s_idle;
			credits_q <= '0;
			req_sent_q <= 1'b0;
		end else begin
			state_q <= state_d;
			credits_q <= credits_d;
			if (mem_req_valid_o) begin
				req_sent_q <= 1'b1;
			end else if (mem_rsp_valid_i) begin
				req_sent_q <= 1'b0;
			end
		end
	end

	// same value the datapath marks busy
	always_ff @(posedge clk) begin
		if (set_busy_o) begin
			pf_way_q <= obl_lru_i;
		end
	end

endmodule : i_cache_control

`default_nettype wire

// File: src/i_cache_perf.sv
// ----------------------------------------------------------------------
// instruction cache performance counters
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module i_cache_perf (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      ev_hit_i,
	input  logic                      ev_pf_hit_i,
	input  logic                      ev_miss_i,
	input  logic                      ev_miss_cycle_i,
	output icache_pkg::perf_counts_t  perf_o
);
	import icache_pkg::*;

	localparam int NUM_CNT = 4;

	// counter slots
	localparam int CNT_HIT = 0;
	localparam int CNT_PF_HIT = 1;
	localparam int CNT_MISS = 2;
	localparam int CNT_MISS_CYCLE = 3;

	logic [NUM_CNT-1:0] ev;
	cnt_t cnt_q [NUM_CNT];

	// strobes gathered in slot order
	always_comb begin
		ev = '0;
		ev[CNT_HIT] = ev_hit_i;
		ev[CNT_PF_HIT] = ev_pf_hit_i;
		ev[CNT_MISS] = ev_miss_i;
		ev[CNT_MISS_CYCLE] = ev_miss_cycle_i;
	end

	// each counter steps on the edge after its strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_CNT; i++) begin
				cnt_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NUM_CNT; i++) begin
				if (ev[i]) begin
					// wraps silently on overflow
					cnt_q[i] <= cnt_q[i] + cnt_t'(1);
				end
			end
		end
	end

	assign perf_o.hits = cnt_q[CNT_HIT];
	assign perf_o.pf_hits = cnt_q[CNT_PF_HIT];
	assign perf_o.misses = cnt_q[CNT_MISS];
	assign perf_o.miss_cycles = cnt_q[CNT_MISS_CYCLE];

endmodule : i_cache_perf

`default_nettype wire

// File: src/i_cache.sv
// ----------------------------------------------------------------------
// prefetching instruction cache top
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module i_cache #(
	parameter int SET_BITS = 4,
	parameter int MEM_CREDITS = 2
) (
	input  logic                      clk,
	input  logic                      rst,
	input  icache_pkg::cpu_req_t      cpu_req_i,
	output icache_pkg::cpu_rsp_t      cpu_rsp_o,
	input  logic                      mem_credit_i,
	output icache_pkg::mem_req_t      mem_req_o,
	input  icache_pkg::mem_rsp_t      mem_rsp_i,
	output icache_pkg::perf_counts_t  perf_o
);
	import icache_pkg::*;

	// datapath status
	logic hit;
	logic hit_way;
	logic obl_hit;
	logic obl_busy;
	logic lru;
	logic obl_lru;
	logic hit_prefetched;
	word_t rdata;
	addr_t fill_addr;

	// control to datapath
	logic way_sel;
	logic load_line;
	logic load_lru;
	logic prefetch_sel;
	logic set_busy;
	logic clr_busy;
	logic set_prefetched;
	logic clr_prefetched;

	logic resp;
	logic mem_req_valid;

	// perf strobes
	logic ev_hit;
	logic ev_pf_hit;
	logic ev_miss;
	logic ev_miss_cycle;

	i_cache_datapath #(
		.SET_BITS (SET_BITS)
	) datapath (
		.clk              (clk),
		.rst              (rst),
		.cpu_addr_i       (cpu_req_i.addr),
		.way_sel_i        (way_sel),
		.load_line_i      (load_line),
		.load_lru_i       (load_lru),
		.prefetch_sel_i   (prefetch_sel),
		.set_busy_i       (set_busy),
		.clr_busy_i       (clr_busy),
		.set_prefetched_i (set_prefetched),
		.clr_prefetched_i (clr_prefetched),
		.fill_line_i      (mem_rsp_i.line),
		.hit_o            (hit),
		.hit_way_o        (hit_way),
		.obl_hit_o        (obl_hit),
		.obl_busy_o       (obl_busy),
		.lru_o            (lru),
		.obl_lru_o        (obl_lru),
		.hit_prefetched_o (hit_prefetched),
		.rdata_o          (rdata),
		.fill_addr_o      (fill_addr)
	);

	i_cache_control #(
		.MEM_CREDITS (MEM_CREDITS)
	) control (
		.clk              (clk),
		.rst              (rst),
		.cpu_req_i        (cpu_req_i),
		.resp_o           (resp),
		.hit_i            (hit),
		.hit_way_i        (hit_way),
		.obl_hit_i        (obl_hit),
		.obl_busy_i       (obl_busy),
		.lru_i            (lru),
		.obl_lru_i        (obl_lru),
		.hit_prefetched_i (hit_prefetched),
		.way_sel_o        (way_sel),
		.load_line_o      (load_line),
		.load_lru_o       (load_lru),
		.prefetch_sel_o   (prefetch_sel),
		.set_busy_o       (set_busy),
		.clr_busy_o       (clr_busy),
		.set_prefetched_o (set_prefetched),
		.clr_prefetched_o (clr_prefetched),
		.mem_credit_i     (mem_credit_i),
		.mem_req_valid_o  (mem_req_valid),
		.mem_rsp_valid_i  (mem_rsp_i.valid),
		.ev_hit_o         (ev_hit),
		.ev_pf_hit_o      (ev_pf_hit),
		.ev_miss_o        (ev_miss),
		.ev_miss_cycle_o  (ev_miss_cycle)
	);

	i_cache_perf perf (
		.clk             (clk),
		.rst             (rst),
		.ev_hit_i        (ev_hit),
		.ev_pf_hit_i     (ev_pf_hit),
		.ev_miss_i       (ev_miss),
		.ev_miss_cycle_i (ev_miss_cycle),
		.perf_o          (perf_o)
	);

	// word and request address go straight out
	assign cpu_rsp_o.resp = resp;
	assign cpu_rsp_o.rdata = rdata;
	assign mem_req_o.valid = mem_req_valid;
	assign mem_req_o.addr = fill_addr;

endmodule : i_cache

`default_nettype wire

// File: dv/tb_i_cache_model.sv
// ----------------------------------------------------------------------
// memory responder and cache reference model
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_i_cache_model #(
	parameter int SET_BITS = 4,
	parameter int MEM_CREDITS = 2,
	parameter int MAX_LAT = 8,
	parameter int MAX_CREDIT_DELAY = 6,
	parameter int SAMPLE_DELAY = 10
) (
	input  logic                      clk,
	input  logic                      rst,
	input  icache_pkg::cpu_req_t      cpu_req_i,
	input  icache_pkg::cpu_rsp_t      cpu_rsp_i,
	input  icache_pkg::mem_req_t      mem_req_i,
	output logic                      mem_credit_o,
	output icache_pkg::mem_rsp_t      mem_rsp_o,
	output icache_pkg::perf_counts_t  tally_o,
	output logic                      idle_o,
	output int                        errors_o
);
	import icache_pkg::*;

	localparam int SETS = 1 << SET_BITS;

	typedef enum {fill_none, fill_demand, fill_prefetch} fill_kind_e;

	// mirrored cache state with the full line address per way
	addr_t line_q [2][SETS];
	bit valid_q [2][SETS];
	bit busy_q [2][SETS];
	bit pf_q [2][SETS];
	bit lru_q [SETS];
	fill_kind_e kind;
	addr_t fill_addr;
	bit fill_way;
	// memory side bookkeeping
	bit out_pending;
	addr_t out_addr;
	int lat_cnt;
	int credits;
	int credit_wait;
	bit in_reset;

	assign idle_o = (kind == fill_none) && !out_pending;

	// instruction word stored at a word address
	// odd multiplier keeps every word unique
	function automatic word_t word_at(addr_t a);
		return (a * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
	endfunction

	function automatic line_t build_line(addr_t base);
		line_t l;
		for (int i = 0; i < LINE_WORDS; i++) begin
			l[i*32 +: 32] = word_at(base + addr_t'(i));
		end
		return l;
	endfunction

	function automatic addr_t line_of(addr_t a);
		return {a[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
	endfunction

	function automatic int set_of(addr_t line);
		return int'(line[OFFSET_BITS +: SET_BITS]);
	endfunction

	function automatic bit lookup(addr_t line, output bit way);
		int s;
		s = set_of(line);
		way = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (valid_q[w][s] && (line_q[w][s] == line)) begin
				way = (w == 1);
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic report_mismatch(string name, logic [31:0] expv, logic [31:0] actv);
		errors_o++;
		$display("Error: %s expected %h actual %h", name, expv, actv);
	endtask

	task automatic report_fault(string what);
		errors_o++;
		$display("Error: %s", what);
	endtask

	task automatic clear_model();
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < 2; w++) begin
				line_q[w][s] = '0;
				valid_q[w][s] = 1'b0;
				busy_q[w][s] = 1'b0;
				pf_q[w][s] = 1'b0;
			end
			lru_q[s] = 1'b0;
		end
		kind = fill_none;
		fill_addr = '0;
		fill_way = 1'b0;
		out_pending = 1'b0;
		out_addr = '0;
		lat_cnt = 0;
		credits = 0;
		credit_wait = 0;
		tally_o = '0;
	endtask

	// response after a random latency and credits at random gaps
	task automatic drive_memory();
		mem_credit_o = 1'b0;
		mem_rsp_o = '0;
		if (in_reset) begin
			return;
		end
		if (out_pending) begin
			if (lat_cnt == 0) begin
				mem_rsp_o.valid = 1'b1;
				mem_rsp_o.line = build_line(out_addr);
			end else begin
				lat_cnt--;
			end
		end
		if (credit_wait > 0) begin
			credit_wait--;
		end else if (credits < MEM_CREDITS) begin
			mem_credit_o = 1'b1;
			credit_wait = int'($urandom % MAX_CREDIT_DELAY);
		end
	endtask

	// one cycle of ports taken before the rising edge
	task automatic observe();
		fill_kind_e kind_now;
		addr_t dem;
		addr_t nxt;
		int set;
		int nset;
		int fset;
		bit way;
		bit nway;
		bit hit;
		bit exp_resp;
		kind_now = kind;
		exp_resp = 1'b0;
		dem = line_of(cpu_req_i.addr);
		nxt = dem + addr_t'(LINE_WORDS);
		set = set_of(dem);
		nset = set_of(nxt);

		if (mem_req_i.valid) begin
			assert (credits > 0) else
				report_fault("memory request issued with no credit held");
			assert (!out_pending) else
				report_fault("second memory request while one is outstanding");
			assert (kind_now != fill_none) else
				report_fault("memory request with no fill pending");
			assert (mem_req_i.addr == fill_addr) else
				report_mismatch("request address", fill_addr, mem_req_i.addr);
			out_pending = 1'b1;
			out_addr = mem_req_i.addr;
			lat_cnt = int'($urandom % MAX_LAT);
			credits--;
		end
		if (mem_credit_o) begin
			credits++;
		end
		if (kind_now == fill_demand) begin
			tally_o.miss_cycles += cnt_t'(1);
		end

		// no demand service during a demand load or in a prefetch fill cycle
		if (cpu_req_i.read && (kind_now != fill_demand) &&
				!((kind_now == fill_prefetch) && mem_rsp_o.valid)) begin
			hit = lookup(dem, way) && !busy_q[0][set] && !busy_q[1][set];
			if (hit) begin
				exp_resp = 1'b1;
				tally_o.hits += cnt_t'(1);
				if (pf_q[way][set]) begin
					tally_o.pf_hits += cnt_t'(1);
					pf_q[way][set] = 1'b0;
				end
				// lookahead line absent and idle gets its lru way reserved
				if ((kind_now == fill_none) && !lookup(nxt, nway) &&
						!busy_q[0][nset] && !busy_q[1][nset]) begin
					kind = fill_prefetch;
					fill_addr = nxt;
					fill_way = lru_q[nset];
					busy_q[fill_way][nset] = 1'b1;
				end
				lru_q[set] = !way;
			end else if (kind_now == fill_none) begin
				tally_o.misses += cnt_t'(1);
				kind = fill_demand;
				fill_addr = dem;
			end
		end

		assert (cpu_rsp_i.resp == exp_resp) else
			report_mismatch("response flag", 32'(exp_resp), 32'(cpu_rsp_i.resp));
		if (exp_resp && cpu_rsp_i.resp) begin
			assert (cpu_rsp_i.rdata == word_at(cpu_req_i.addr)) else
				report_mismatch("returned word", word_at(cpu_req_i.addr), cpu_rsp_i.rdata);
		end

		// line written on the edge that ends the response cycle
		if (mem_rsp_o.valid) begin
			fset = set_of(fill_addr);
			way = (kind_now == fill_prefetch) ? fill_way : lru_q[fset];
			line_q[way][fset] = fill_addr;
			valid_q[way][fset] = 1'b1;
			pf_q[way][fset] = (kind_now == fill_prefetch);
			busy_q[way][fset] = 1'b0;
			kind = fill_none;
			out_pending = 1'b0;
		end
	endtask

	initial begin
		errors_o = 0;
		in_reset = 1'b1;
		clear_model();
		mem_credit_o = 1'b0;
		mem_rsp_o = '0;
		forever begin
			@(negedge clk);
			drive_memory();
			#(SAMPLE_DELAY);
			in_reset = rst;
			if (rst) begin
				clear_model();
			end else begin
				observe();
			end
		end
	end

endmodule : tb_i_cache_model

`default_nettype wire

// File: dv/tb_i_cache.sv
// ----------------------------------------------------------------------
// instruction cache testbench
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_i_cache;
	import icache_pkg::*;

	localparam int SET_BITS = 4;
	localparam int MEM_CREDITS = 2;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 10;
	localparam int SEED = 48;
	localparam int N_REQ = 1500;
	localparam int MAX_LAT = 8;
	localparam int MAX_CREDIT_DELAY = 6;
	// outputs taken a quarter period after the falling edge
	localparam int SAMPLE_DELAY = CLK_PERIOD / 4;
	localparam int TIMEOUT_CYCLES = N_REQ * (MAX_LAT + MAX_CREDIT_DELAY) * 3;

	logic clk;
	logic rst;
	cpu_req_t cpu_req;
	cpu_rsp_t cpu_rsp;
	logic mem_credit;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;
	perf_counts_t perf;
	perf_counts_t tally;
	logic model_idle;
	int model_errors;
	int count_errors;
	int served;
	int cycles;
	int unsigned seed_val;
	bit rsp_seen;

	i_cache #(
		.SET_BITS    (SET_BITS),
		.MEM_CREDITS (MEM_CREDITS)
	) DUT (
		.clk          (clk),
		.rst          (rst),
		.cpu_req_i    (cpu_req),
		.cpu_rsp_o    (cpu_rsp),
		.mem_credit_i (mem_credit),
		.mem_req_o    (mem_req),
		.mem_rsp_i    (mem_rsp),
		.perf_o       (perf)
	);

	tb_i_cache_model #(
		.SET_BITS         (SET_BITS),
		.MEM_CREDITS      (MEM_CREDITS),
		.MAX_LAT          (MAX_LAT),
		.MAX_CREDIT_DELAY (MAX_CREDIT_DELAY),
		.SAMPLE_DELAY     (SAMPLE_DELAY)
	) model (
		.clk          (clk),
		.rst          (rst),
		.cpu_req_i    (cpu_req),
		.cpu_rsp_i    (cpu_rsp),
		.mem_req_i    (mem_req),
		.mem_credit_o (mem_credit),
		.mem_rsp_o    (mem_rsp),
		.tally_o      (tally),
		.idle_o       (model_idle),
		.errors_o     (model_errors)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// mostly sequential runs, some jumps into a small aliasing pool
	function automatic addr_t next_addr(addr_t prev);
		int unsigned pick;
		pick = $urandom % 20;
		if (pick < 15) begin
			return prev + addr_t'(1);
		end
		if (pick < 19) begin
			// four tags per set, so two ways must evict
			return addr_t'(32'h1000 + (($urandom % 4) << 7) + ($urandom % 128));
		end
		return addr_t'(32'h4_0000 + ($urandom % 4096));
	endfunction

	task automatic compare_counter(string name, cnt_t expv, cnt_t actv);
		assert (actv == expv) else begin
			count_errors++;
			$display("Error: %s expected %0d actual %0d", name, expv, actv);
		end
	endtask

	task automatic print_totals();
		$display("errors: %0d total, %0d from cache behavior, %0d from counters",
			model_errors + count_errors, model_errors, count_errors);
	endtask

	initial begin
		seed_val = $urandom(SEED);
		clk = 1'b0;
		rst = 1'b1;
		cpu_req = '0;
		served = 0;
		rsp_seen = 1'b0;
		count_errors = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		cpu_req.addr = 32'h1000;

		// request held until its response, then a new one or a gap
		while (served < N_REQ) begin
			@(negedge clk);
			if (rsp_seen || !cpu_req.read) begin
				if (rsp_seen && ($urandom % 8 == 0)) begin
					cpu_req.read = 1'b0;
				end else begin
					cpu_req.read = 1'b1;
					cpu_req.addr = next_addr(cpu_req.addr);
				end
				rsp_seen = 1'b0;
			end
			#(SAMPLE_DELAY);
			if (cpu_req.read && cpu_rsp.resp) begin
				rsp_seen = 1'b1;
				served++;
			end
		end

		// drain any prefetch still in flight
		@(negedge clk);
		cpu_req.read = 1'b0;
		while (!model_idle) begin
			@(negedge clk);
		end
		repeat (2) @(negedge clk);
		#(SAMPLE_DELAY);

		compare_counter("hits counter", tally.hits, perf.hits);
		compare_counter("prefetched hits counter", tally.pf_hits, perf.pf_hits);
		compare_counter("misses counter", tally.misses, perf.misses);
		compare_counter("miss cycles counter", tally.miss_cycles, perf.miss_cycles);

		print_totals();
		if ((model_errors + count_errors) == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// limit scales with request count and worst memory delays
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
		print_totals();
		$display("Simulation failed");
		$finish;
	end

endmodule : tb_i_cache

`default_nettype wire

// File: sources.f
src/icache_pkg.sv
src/i_cache_datapath.sv
src/i_cache_control.sv
src/i_cache_perf.sv
src/i_cache.sv
dv/tb_i_cache_model.sv
dv/tb_i_cache.sv

// File: run.sh
#!/bin/sh
# build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_i_cache -o tb_i_cache

./obj_dir/tb_i_cache > sim.log
cat sim.log

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
